// File: compile.f
src/atm_cell_pkg.sv
src/switch_ctl_pkg.sv
src/switch_ctl_if.sv
src/hec_calc.sv
src/ingress_arbiter.sv
src/cell_sequencer.sv
src/header_translator.sv
src/egress_port.sv
src/atm_switch_top.sv
bench/tb_clock_gen.sv
bench/tb_atm_switch.sv

// File: Bender.yml
package:
  name: atm_switch

sources:
  - src/atm_cell_pkg.sv
  - src/switch_ctl_pkg.sv
  - src/switch_ctl_if.sv
  - src/hec_calc.sv
  - src/ingress_arbiter.sv
  - src/cell_sequencer.sv
  - src/header_translator.sv
  - src/egress_port.sv
  - src/atm_switch_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_atm_switch.sv

// File: bench/tb_atm_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_atm_switch
  import atm_cell_pkg::*, switch_ctl_pkg::*;
();

  localparam int          num_ports    = 4;
  localparam int          reset_cycles = 5;
  localparam int          n_rows       = 6;
  localparam int          cycle_limit  = n_rows * 40 + reset_cycles;
  localparam logic [31:0] seed         = 32'h406a7752;

  // one stimulus row with its expected delivery in exp_tx
  typedef struct packed {
    logic [num_ports-1:0] src;
    logic [gfc_w-1:0]     gfc;
    logic [uni_vpi_w-1:0] vpi;
    logic [vci_w-1:0]     vci;
    logic                 clp;
    logic [pt_w-1:0]      pt;
    logic                 bad_hec;
    logic [max_ports-1:0] mask;
    logic [nni_vpi_w-1:0] new_vpi;
    logic [num_ports-1:0] exp_tx;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic [num_ports-1:0] rx_req;
  logic [num_ports-1:0] rx_ack;
  logic [gfc_w-1:0]     rx_gfc     [num_ports];
  logic [uni_vpi_w-1:0] rx_vpi     [num_ports];
  logic [vci_w-1:0]     rx_vci     [num_ports];
  logic                 rx_clp     [num_ports];
  logic [pt_w-1:0]      rx_pt      [num_ports];
  logic [hec_w-1:0]     rx_hec     [num_ports];
  payload_t             rx_payload [num_ports];
  logic                 fwd_rden;
  logic [uni_vpi_w-1:0] fwd_addr;
  fwd_entry_t           fwd_data;
  logic [num_ports-1:0] tx_req;
  logic [num_ports-1:0] tx_ack;
  logic [nni_vpi_w-1:0] tx_vpi     [num_ports];
  logic [vci_w-1:0]     tx_vci     [num_ports];
  logic                 tx_clp     [num_ports];
  logic [pt_w-1:0]      tx_pt      [num_ports];
  logic [hec_w-1:0]     tx_hec     [num_ports];
  payload_t             tx_payload [num_ports];

  row_t       rows        [n_rows];
  string      row_name    [n_rows] = '{"unicast", "bad_hec", "multicast", "empty_mask",
                                       "after_empty", "priority"};
  string      cur_name;
  row_t       row;
  payload_t   src_payload [num_ports];
  fwd_entry_t fwd_table   [256];
  logic [2:0] ack_delay   [num_ports][16];
  logic [3:0] pool_idx    [num_ports];
  logic       busy        [num_ports];
  logic [2:0] wait_left   [num_ports];
  int         rx_cnt      [num_ports];
  int         tx_cnt      [num_ports];
  int         rd_cnt;
  int         cur_src;
  int         cycles;
  int         errors;

  tb_clock_gen #(.reset_cycles(reset_cycles)) u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  atm_switch_top #(.num_ports(num_ports)) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_req     (rx_req),
    .rx_ack     (rx_ack),
    .rx_gfc     (rx_gfc),
    .rx_vpi     (rx_vpi),
    .rx_vci     (rx_vci),
    .rx_clp     (rx_clp),
    .rx_pt      (rx_pt),
    .rx_hec     (rx_hec),
    .rx_payload (rx_payload),
    .fwd_rden   (fwd_rden),
    .fwd_addr   (fwd_addr),
    .fwd_data   (fwd_data),
    .tx_req     (tx_req),
    .tx_ack     (tx_ack),
    .tx_vpi     (tx_vpi),
    .tx_vci     (tx_vci),
    .tx_clp     (tx_clp),
    .tx_pt      (tx_pt),
    .tx_hec     (tx_hec),
    .tx_payload (tx_payload)
  );

  // forwarding table read combinationally
  assign fwd_data = fwd_table[fwd_addr];

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////

  // CRC-8 from a zero start over the header MSB first and then the coset
  function automatic logic [hec_w-1:0] header_hec(input logic [hdr_w-1:0] hdr);
    logic [hec_w-1:0] crc;
    crc = '0;
    for (int i = hdr_w - 1; i >= 0; i--) begin
      if (crc[hec_w-1] ^ hdr[i]) begin
        crc = {crc[hec_w-2:0], 1'b0} ^ hec_poly;
      end else begin
        crc = {crc[hec_w-2:0], 1'b0};
      end
    end
    return crc ^ hec_coset;
  endfunction

  function automatic payload_t random_payload();
    payload_t pl;
    for (int i = 0; i < $bits(payload_t) / 32; i++) begin
      pl[32*i +: 32] = $urandom;
    end
    return pl;
  endfunction

  function automatic logic [num_ports-1:0] acked_ports();
    logic [num_ports-1:0] m;
    for (int p = 0; p < num_ports; p++) begin
      m[p] = (rx_cnt[p] != 0);
    end
    return m;
  endfunction

  function automatic int tx_total();
    int sum;
    sum = 0;
    for (int p = 0; p < num_ports; p++) begin
      sum += tx_cnt[p];
    end
    return sum;
  endfunction

  function automatic int lowest_port(input logic [num_ports-1:0] m);
    for (int i = 0; i < num_ports; i++) begin
      if (m[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic bit row_complete();
    return (acked_ports() == row.src) &&
           (tx_total() == $countones(row.exp_tx) * $countones(row.src));
  endfunction

  task automatic compare(input string what, input logic [511:0] exp, input logic [511:0] act);
    if (act !== exp) begin
      errors++;
      $display("error: %s %s expected %0h actual %0h", cur_name, what, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // cell on a masked port against the cell of the last acked source
  task automatic check_cell(input int p);
    logic [hdr_w-1:0] hdr;
    hdr = {row.new_vpi, row.vci, row.clp, row.pt};
    compare($sformatf("port %0d vpi", p), row.new_vpi, tx_vpi[p]);
    compare($sformatf("port %0d vci", p), row.vci, tx_vci[p]);
    compare($sformatf("port %0d clp/pt", p), {row.clp, row.pt}, {tx_clp[p], tx_pt[p]});
    compare($sformatf("port %0d hec", p), header_hec(hdr), tx_hec[p]);
    compare($sformatf("port %0d payload", p), src_payload[cur_src], tx_payload[p]);
  endtask

  task automatic start_row(input int r);
    row_t             rw;
    payload_t         pl;
    logic [hec_w-1:0] hec;
    rw  = rows[r];
    hec = header_hec({rw.gfc, rw.vpi, rw.vci, rw.clp, rw.pt});
    if (rw.bad_hec) begin
      hec = ~hec;
    end
    cur_name          <= row_name[r];
    row               <= rw;
    rd_cnt            <= 0;
    fwd_table[rw.vpi] <= {rw.mask, rw.new_vpi};
    for (int p = 0; p < num_ports; p++) begin
      rx_cnt[p] <= 0;
      tx_cnt[p] <= 0;
      if (rw.src[p]) begin
        pl              = random_payload();
        src_payload[p] <= pl;
        rx_gfc[p]      <= rw.gfc;
        rx_vpi[p]      <= rw.vpi;
        rx_vci[p]      <= rw.vci;
        rx_clp[p]      <= rw.clp;
        rx_pt[p]       <= rw.pt;
        rx_hec[p]      <= hec;
        rx_payload[p]  <= pl;
      end
    end
    rx_req <= rw.src;
  endtask

  task automatic end_checks();
    for (int p = 0; p < num_ports; p++) begin
      compare($sformatf("port %0d rx acks", p), row.src[p], rx_cnt[p]);
      compare($sformatf("port %0d tx acks", p),
              row.exp_tx[p] ? $countones(row.src) : 0, tx_cnt[p]);
    end
    compare("table reads", $countones(row.src), rd_cnt);
    compare("tx_req after row", '0, tx_req);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // receive sources and transmit sinks with the idle port watch
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : port_models
    int left;
    if (rst_n) begin
      if (fwd_rden) begin
        compare("table address", row.vpi, fwd_addr);
        rd_cnt <= rd_cnt + 1;
      end
      for (int p = 0; p < num_ports; p++) begin
        if (rx_ack[p]) begin
          compare("acked port", lowest_port(row.src & ~acked_ports()), p);
          // earlier cell must be fully delivered first
          compare("tx acks before rx ack",
                  $countones(row.exp_tx) * $countones(acked_ports()), tx_total());
          rx_req[p] <= 1'b0;
          rx_cnt[p] <= rx_cnt[p] + 1;
          cur_src   <= p;
        end
        if (!row.exp_tx[p]) begin
          compare($sformatf("port %0d unused outputs", p), '0,
                  {tx_req[p], tx_vpi[p], tx_vci[p], tx_clp[p], tx_pt[p], tx_hec[p],
                   tx_payload[p]});
        end
        if (tx_ack[p]) begin
          tx_ack[p] <= 1'b0;
        end else if (tx_req[p]) begin
          if (!busy[p]) begin
            check_cell(p);
            left        = ack_delay[p][pool_idx[p]];
            pool_idx[p] <= pool_idx[p] + 1'b1;
          end else begin
            left = wait_left[p];
          end
          if (left == 0) begin
            tx_ack[p] <= 1'b1;
            busy[p]   <= 1'b0;
            tx_cnt[p] <= tx_cnt[p] + 1;
          end else begin
            busy[p]      <= 1'b1;
            wait_left[p] <= left - 1;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout reached after %0d cycles without finishing the rows", cycles);
      $display("TESTS FAILED");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  initial begin
    errors   = 0;
    cycles   = 0;
    cur_src  = 0;
    rd_cnt   = 0;
    cur_name = "reset";
    row      = '0;
    rx_req   = '0;
    tx_ack   = '0;
    for (int p = 0; p < num_ports; p++) begin
      rx_gfc[p]      = '0;
      rx_vpi[p]      = '0;
      rx_vci[p]      = '0;
      rx_clp[p]      = 1'b0;
      rx_pt[p]       = '0;
      rx_hec[p]      = '0;
      rx_payload[p]  = '0;
      src_payload[p] = '0;
      busy[p]        = 1'b0;
      wait_left[p]   = '0;
      pool_idx[p]    = '0;
      rx_cnt[p]      = 0;
      tx_cnt[p]      = 0;
    end
    // unused entries carry an empty mask so the cell is dropped
    for (int a = 0; a < 256; a++) begin
      fwd_table[a] = {8'h00, 4'hf, a[7:0]};
    end
    void'($urandom(seed));
    for (int p = 0; p < num_ports; p++) begin
      for (int k = 0; k < 16; k++) begin
        ack_delay[p][k] = $urandom_range(4, 0);
      end
    end

    //        src      gfc   vpi    vci       clp   pt      bad   mask   new_vpi  exp_tx
    rows[0] = '{4'b0100, 4'h3, 8'h21, 16'h1234, 1'b0, 3'b010, 1'b0, 8'h02, 12'ha5c, 4'b0010};
    rows[1] = '{4'b0010, 4'ha, 8'h22, 16'h0042, 1'b1, 3'b000, 1'b1, 8'h0c, 12'h3f0, 4'b0000};
    rows[2] = '{4'b1001, 4'h0, 8'h40, 16'hbeef, 1'b1, 3'b101, 1'b0, 8'h0b, 12'h801, 4'b1011};
    rows[3] = '{4'b0001, 4'h5, 8'h55, 16'h0100, 1'b0, 3'b001, 1'b0, 8'h00, 12'h123, 4'b0000};
    rows[4] = '{4'b0100, 4'h0, 8'h56, 16'h0101, 1'b0, 3'b011, 1'b0, 8'h01, 12'h456, 4'b0001};
    rows[5] = '{4'b0110, 4'hf, 8'h77, 16'h7777, 1'b1, 3'b111, 1'b0, 8'h08, 12'hfff, 4'b1000};

    wait (rst_n === 1'b1);
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      start_row(r);
      do begin
        @(posedge clk);
      end while (!row_complete());
      // let the sequencer fall back to idle and clear the mask
      repeat (4) @(posedge clk);
      end_checks();
    end

    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 2,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

// File: src/atm_switch_top.sv
`timescale 1ns/1ps
`default_nettype none

module atm_switch_top
  import atm_cell_pkg::*, switch_ctl_pkg::*;
#(
  parameter int num_ports = default_num_ports
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [num_ports-1:0]          rx_req,
  output logic [num_ports-1:0]          rx_ack,
  input  logic [gfc_w-1:0]              rx_gfc     [num_ports],
  input  logic [uni_vpi_w-1:0]          rx_vpi     [num_ports],
  input  logic [vci_w-1:0]              rx_vci     [num_ports],
  input  logic                          rx_clp     [num_ports],
  input  logic [pt_w-1:0]               rx_pt      [num_ports],
  input  logic [hec_w-1:0]              rx_hec     [num_ports],
  input  payload_t                      rx_payload [num_ports],
  output logic                          fwd_rden,
  output logic [uni_vpi_w-1:0]          fwd_addr,
  input  logic [$bits(fwd_entry_t)-1:0] fwd_data,
  output logic [num_ports-1:0]          tx_req,
  input  logic [num_ports-1:0]          tx_ack,
  output logic [nni_vpi_w-1:0]          tx_vpi     [num_ports],
  output logic [vci_w-1:0]              tx_vci     [num_ports],
  output logic                          tx_clp     [num_ports],
  output logic [pt_w-1:0]               tx_pt      [num_ports],
  output logic [hec_w-1:0]              tx_hec     [num_ports],
  output payload_t                      tx_payload [num_ports]
);

  logic                 any_grant;
  logic                 hec_err;
  logic                 mask_empty;
  logic                 all_done;
  logic [num_ports-1:0] fwd_mask;
  logic [num_ports-1:0] done;
  uni_cell_t            uni_cell;
  nni_cell_t            nni_cell;

  switch_ctl_if ctl_if ();

  cell_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (ctl_if.ctl),
    .any_grant  (any_grant),
    .hec_err    (hec_err),
    .mask_empty (mask_empty),
    .all_done   (all_done)
  );

  ingress_arbiter #(.num_ports(num_ports)) u_ingress (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (ctl_if.dp),
    .rx_req     (rx_req),
    .rx_ack     (rx_ack),
    .rx_gfc     (rx_gfc),
    .rx_vpi     (rx_vpi),
    .rx_vci     (rx_vci),
    .rx_clp     (rx_clp),
    .rx_pt      (rx_pt),
    .rx_hec     (rx_hec),
    .rx_payload (rx_payload),
    .fwd_rden   (fwd_rden),
    .fwd_addr   (fwd_addr),
    .any_grant  (any_grant),
    .uni_cell   (uni_cell)
  );

  header_translator #(.num_ports(num_ports)) u_xlate (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (ctl_if.dp),
    .uni_cell   (uni_cell),
    .fwd_data   (fwd_data),
    .hec_err    (hec_err),
    .mask_empty (mask_empty),
    .fwd_mask   (fwd_mask),
    .nni_cell   (nni_cell)
  );

  ////////////////////////////////////////////////////////////////////////////
  // one egress slice per port
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < num_ports; i++) begin : g_egress
    egress_port u_egress (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctl        (ctl_if.dp),
      .fwd_sel    (fwd_mask[i]),
      .nni_cell   (nni_cell),
      .tx_req     (tx_req[i]),
      .tx_ack     (tx_ack[i]),
      .tx_vpi     (tx_vpi[i]),
      .tx_vci     (tx_vci[i]),
      .tx_clp     (tx_clp[i]),
      .tx_pt      (tx_pt[i]),
      .tx_hec     (tx_hec[i]),
      .tx_payload (tx_payload[i]),
      .done       (done[i])
    );
  end

  assign all_done = &done;

endmodule

`default_nettype wire

// File: src/egress_port.sv
`timescale 1ns/1ps
`default_nettype none

module egress_port
  import atm_cell_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  switch_ctl_if.dp             ctl,
  input  logic                 fwd_sel,
  input  nni_cell_t            nni_cell,
  output logic                 tx_req,
  input  logic                 tx_ack,
  output logic [nni_vpi_w-1:0] tx_vpi,
  output logic [vci_w-1:0]     tx_vci,
  output logic                 tx_clp,
  output logic [pt_w-1:0]      tx_pt,
  output logic [hec_w-1:0]     tx_hec,
  output payload_t             tx_payload,
  output logic                 done
);

  nni_cell_t tx_cell;

  // ack wins over a new issue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_req <= 1'b0;
    end else if (tx_ack) begin
      tx_req <= 1'b0;
    end else if (ctl.issue && fwd_sel) begin
      tx_req <= 1'b1;
    end
  end

  // unselected ports count as done at once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (!ctl.collect) begin
      done <= 1'b0;
    end else if (tx_ack || !fwd_sel) begin
      done <= 1'b1;
    end
  end

  assign tx_cell    = fwd_sel ? nni_cell : '0;
  assign tx_vpi     = tx_cell.vpi;
  assign tx_vci     = tx_cell.vci;
  assign tx_clp     = tx_cell.clp;
  assign tx_pt      = tx_cell.pt;
  assign tx_hec     = tx_cell.hec;
  assign tx_payload = tx_cell.payload;

endmodule

`default_nettype wire

// File: src/header_translator.sv
`timescale 1ns/1ps
`default_nettype none

module header_translator
  import atm_cell_pkg::*, switch_ctl_pkg::*;
#(
  parameter int num_ports = default_num_ports
) (
  input  logic                 clk,
  input  logic                 rst_n,
  switch_ctl_if.dp             ctl,
  input  uni_cell_t            uni_cell,
  input  fwd_entry_t           fwd_data,
  output logic                 hec_err,
  output logic                 mask_empty,
  output logic [num_ports-1:0] fwd_mask,
  output nni_cell_t            nni_cell
);

  fwd_entry_t       entry_q;
  logic [hec_w-1:0] nni_hec_q;
  logic [hdr_w-1:0] hec_in;
  logic [hec_w-1:0] hec_out;

  // last idle cycle is the grant cycle, so this holds the granted entry
  always_ff @(posedge clk) begin
    if (ctl.grant_en) begin
      entry_q <= fwd_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // shared HEC unit: UNI check in lookup, NNI build in checksum
  ////////////////////////////////////////////////////////////////////////////
  assign hec_in = ctl.checksum ? nni_hdr(nni_cell) : uni_hdr(uni_cell);

  hec_calc u_hec_calc (
    .hdr (hec_in),
    .hec (hec_out)
  );

  assign hec_err = ctl.lookup && (hec_out != uni_cell.hec);

  always_ff @(posedge clk) begin
    if (ctl.checksum) begin
      nni_hec_q <= hec_out;
    end
  end

  // mask only opens for a cell whose header passed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fwd_mask <= '0;
    end else if (ctl.grant_en) begin
      fwd_mask <= '0;
    end else if (ctl.lookup && !hec_err) begin
      fwd_mask <= entry_q.port_mask[num_ports-1:0];
    end
  end

  assign mask_empty = ~|fwd_mask;

  // gfc dropped, vpi swapped
  assign nni_cell = '{
    vpi:     entry_q.new_vpi,
    vci:     uni_cell.vci,
    clp:     uni_cell.clp,
    pt:      uni_cell.pt,
    hec:     nni_hec_q,
    payload: uni_cell.payload
  };

endmodule

`default_nettype wire

// File: src/cell_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cell_sequencer
  import switch_ctl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  switch_ctl_if.ctl ctl,
  input  logic      any_grant,
  input  logic      hec_err,
  input  logic      mask_empty,
  input  logic      all_done
);

  seq_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (any_grant) begin
            state <= st_lookup;
          end
        end
        // bad header ends the cell here
        st_lookup: begin
          state <= hec_err ? st_idle : st_checksum;
        end
        st_checksum: begin
          state <= st_issue;
        end
        st_issue: begin
          state <= mask_empty ? st_idle : st_collect;
        end
        // hold until every masked port has acked
        st_collect: begin
          if (all_done) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign ctl.grant_en = (state == st_idle);
  assign ctl.lookup   = (state == st_lookup);
  assign ctl.checksum = (state == st_checksum);
  assign ctl.issue    = (state == st_issue);
  assign ctl.collect  = (state == st_collect);

endmodule

`default_nettype wire

// File: src/ingress_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_arbiter
  import atm_cell_pkg::*, switch_ctl_pkg::*;
#(
  parameter int num_ports = default_num_ports
) (
  input  logic                 clk,
  input  logic                 rst_n,
  switch_ctl_if.dp             ctl,
  input  logic [num_ports-1:0] rx_req,
  output logic [num_ports-1:0] rx_ack,
  input  logic [gfc_w-1:0]     rx_gfc     [num_ports],
  input  logic [uni_vpi_w-1:0] rx_vpi     [num_ports],
  input  logic [vci_w-1:0]     rx_vci     [num_ports],
  input  logic                 rx_clp     [num_ports],
  input  logic [pt_w-1:0]      rx_pt      [num_ports],
  input  logic [hec_w-1:0]     rx_hec     [num_ports],
  input  payload_t             rx_payload [num_ports],
  output logic                 fwd_rden,
  output logic [uni_vpi_w-1:0] fwd_addr,
  output logic                 any_grant,
  output uni_cell_t            uni_cell
);

  logic [num_ports-1:0] grant;
  uni_cell_t            sel_cell;

  ////////////////////////////////////////////////////////////////////////////
  // fixed priority, port 0 highest
  ////////////////////////////////////////////////////////////////////////////

  // isolate lowest set request bit
  assign grant     = ctl.grant_en ? (rx_req & (~rx_req + 1'b1)) : '0;
  assign any_grant = |grant;

  // grant is one-hot so at most one port lands here
  always_comb begin
    sel_cell = '0;
    for (int i = 0; i < num_ports; i++) begin
      if (grant[i]) begin
        sel_cell.gfc     = rx_gfc[i];
        sel_cell.vpi     = rx_vpi[i];
        sel_cell.vci     = rx_vci[i];
        sel_cell.clp     = rx_clp[i];
        sel_cell.pt      = rx_pt[i];
        sel_cell.hec     = rx_hec[i];
        sel_cell.payload = rx_payload[i];
      end
    end
  end

  // table read in the grant cycle
  assign fwd_rden = any_grant;
  assign fwd_addr = sel_cell.vpi;

  always_ff @(posedge clk) begin
    if (any_grant) begin
      uni_cell <= sel_cell;
    end
  end

  // ack pulses one cycle after grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_ack <= '0;
    end else begin
      rx_ack <= grant;
    end
  end

endmodule

`default_nettype wire

// File: src/hec_calc.sv
`timescale 1ns/1ps
`default_nettype none

module hec_calc
  import atm_cell_pkg::*;
(
  input  logic [hdr_w-1:0] hdr,
  output logic [hec_w-1:0] hec
);

  logic [hec_w-1:0] crc;
  logic             fb;

  // bit-serial CRC-8 unrolled, MSB of header first
  always_comb begin
    crc = '0;
    fb  = 1'b0;
    for (int i = hdr_w - 1; i >= 0; i--) begin
      fb  = crc[hec_w-1] ^ hdr[i];
      crc = {crc[hec_w-2:0], 1'b0} ^ (fb ? hec_poly : '0);
    end
  end

  assign hec = crc ^ hec_coset;

endmodule

`default_nettype wire

// File: src/switch_ctl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface switch_ctl_if;

  // one strobe per sequencer phase
  logic grant_en;
  logic lookup;
  logic checksum;
  logic issue;
  logic collect;

  modport ctl (
    output grant_en,
    output lookup,
    output checksum,
    output issue,
    output collect
  );

  modport dp (
    input grant_en,
    input lookup,
    input checksum,
    input issue,
    input collect
  );

endinterface

`default_nettype wire

// File: src/switch_ctl_pkg.sv
`default_nettype none

package switch_ctl_pkg;

  localparam int max_ports         = 8;
  localparam int default_num_ports = 4;

  // sequencer phases
  typedef enum logic [2:0] {
    st_idle     = 3'd0,
    st_lookup   = 3'd1,
    st_checksum = 3'd2,
    st_issue    = 3'd3,
    st_collect  = 3'd4
  } seq_state_t;

  // one forwarding table word, mask in the upper byte
  typedef struct packed {
    logic [max_ports-1:0]                   port_mask;
    logic [atm_cell_pkg::nni_vpi_w-1:0]     new_vpi;
  } fwd_entry_t;

endpackage

`default_nettype wire

// File: src/atm_cell_pkg.sv
`default_nettype none

package atm_cell_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // cell field widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int payload_bytes = 48;
  localparam int gfc_w         = 4;
  localparam int uni_vpi_w     = 8;
  localparam int nni_vpi_w     = 12;
  localparam int vci_w         = 16;
  localparam int pt_w          = 3;
  localparam int hec_w         = 8;
  localparam int hdr_w         = 32;

  // HEC generator x^8 + x^2 + x + 1, coset per I.432
  localparam logic [hec_w-1:0] hec_poly  = 8'h07;
  localparam logic [hec_w-1:0] hec_coset = 8'h55;

  typedef logic [8*payload_bytes-1:0] payload_t;

  // header fields first, MSB first, so bits above hec form the header
  typedef struct packed {
    logic [gfc_w-1:0]     gfc;
    logic [uni_vpi_w-1:0] vpi;
    logic [vci_w-1:0]     vci;
    logic                 clp;
    logic [pt_w-1:0]      pt;
    logic [hec_w-1:0]     hec;
    payload_t             payload;
  } uni_cell_t;

  typedef struct packed {
    logic [nni_vpi_w-1:0] vpi;
    logic [vci_w-1:0]     vci;
    logic                 clp;
    logic [pt_w-1:0]      pt;
    logic [hec_w-1:0]     hec;
    payload_t             payload;
  } nni_cell_t;

  function automatic logic [hdr_w-1:0] uni_hdr(input uni_cell_t c);
    return {c.gfc, c.vpi, c.vci, c.clp, c.pt};
  endfunction

  function automatic logic [hdr_w-1:0] nni_hdr(input nni_cell_t c);
    return {c.vpi, c.vci, c.clp, c.pt};
  endfunction

endpackage

`default_nettype wire
